/* bp_pkg.sv */
package bp_pkg;

    // datapath widths
    localparam int PC_W   = 32;
    localparam int INST_W = 32;

    // opcode field in inst[31:26]
    localparam int OP_W   = 6;
    localparam int OP_LSB = 26;

    localparam logic [OP_W-1:0] OP_JIRL    = 6'h13;
    localparam logic [OP_W-1:0] OP_B       = 6'h14;
    localparam logic [OP_W-1:0] OP_BL      = 6'h15;
    localparam logic [OP_W-1:0] OP_COND_LO = 6'h16;
    localparam logic [OP_W-1:0] OP_COND_HI = 6'h1b;

    // btb geometry, tag is pc[13:2]
    localparam int BTB_NUM     = 8;
    localparam int BTB_PTR_W   = 3;
    localparam int BTB_TAG_LSB = 2;
    localparam int BTB_TAG_MSB = 13;
    localparam int BTB_TAG_W   = BTB_TAG_MSB - BTB_TAG_LSB + 1;

    // history and hash width, shared by bht, pht and target cache
    localparam int HIST_W   = 5;
    localparam int HIST_NUM = 1 << HIST_W;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_DIRECT = 2'd1,
        BR_COND   = 2'd2
    } br_class_e;

    // fold upper pc bits into the low bits, two xor terms summed mod 2^HIST_W
    function automatic logic [HIST_W-1:0] pc_hash(input logic [PC_W-1:0] pc);
        logic [PC_W-1:0]   sh16;
        logic [PC_W-1:0]   sh8;
        logic [HIST_W-1:0] term_a;
        logic [HIST_W-1:0] term_b;
        sh16   = pc >> 16;
        sh8    = pc >> 8;
        term_a = pc[HIST_W-1:0] ^ sh16[HIST_W-1:0];
        term_b = pc[HIST_W-1:0] ^ sh8[HIST_W-1:0];
        return term_a + term_b;
    endfunction

    // ring 00 -> 01 -> 11 -> 10 on taken, reverse on not taken
    // msb is the taken prediction
    function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        case (ctr)
            2'b00:   nxt = taken ? 2'b01 : 2'b00;
            2'b01:   nxt = taken ? 2'b11 : 2'b00;
            2'b11:   nxt = taken ? 2'b10 : 2'b01;
            2'b10:   nxt = taken ? 2'b10 : 2'b11;
            default: nxt = 2'b00;
        endcase
        return nxt;
    endfunction

endpackage

/* bp_update_if.sv */
`timescale 1ns/1ps

// resolve bus from a later stage, no back-pressure
interface bp_update_if;

    logic                     upd_valid;
    logic [bp_pkg::PC_W-1:0]  upd_pc;
    bp_pkg::br_class_e        upd_class;
    logic                     upd_taken;
    logic [bp_pkg::PC_W-1:0]  upd_target;

    modport src (
        output upd_valid,
        output upd_pc,
        output upd_class,
        output upd_taken,
        output upd_target
    );

    modport sink (
        input upd_valid,
        input upd_pc,
        input upd_class,
        input upd_taken,
        input upd_target
    );

endinterface

/* pd_ctrl.sv */
`timescale 1ns/1ps

module pd_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid_i,
    input  logic out_ready_i,
    input  logic flush_i,
    input  logic direct_miss_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output logic load_o,
    output logic stall_o
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        HOLD     = 2'd1,
        WAIT_BTB = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   full;
    logic   leave;

    assign full = (state_q != IDLE);

    // a held direct jump without a btb entry is not offered
    assign out_valid_o = full && !direct_miss_i;
    assign stall_o     = full && direct_miss_i;
    assign leave       = out_valid_o && out_ready_i;

    // empty, or emptying this cycle; never during flush
    assign in_ready_o = !flush_i && (!full || leave);
    assign load_o     = in_valid_i && in_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load_o) begin
                    state_d = HOLD;
                end
            end
            HOLD, WAIT_BTB: begin
                if (leave) begin
                    state_d = load_o ? HOLD : IDLE;
                end else if (direct_miss_i) begin
                    state_d = WAIT_BTB;
                end else begin
                    // miss cleared by a resolve write, or back-pressure
                    state_d = HOLD;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
        if (flush_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* pd_decode.sv */
`timescale 1ns/1ps

module pd_decode (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      load_i,
    input  logic [bp_pkg::PC_W-1:0]   pc_i,
    input  logic [bp_pkg::INST_W-1:0] inst_i,
    output logic [bp_pkg::PC_W-1:0]   pc_o,
    output logic [bp_pkg::INST_W-1:0] inst_o,
    output bp_pkg::br_class_e         class_o
);

    logic [bp_pkg::PC_W-1:0]   pc_q;
    logic [bp_pkg::INST_W-1:0] inst_q;
    logic [bp_pkg::OP_W-1:0]   opcode;
    logic                      is_direct;
    logic                      is_cond;

    // cleared payload decodes as a non-branch
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q   <= '0;
            inst_q <= '0;
        end else if (load_i) begin
            pc_q   <= pc_i;
            inst_q <= inst_i;
        end
    end

    assign opcode = inst_q[bp_pkg::OP_LSB +: bp_pkg::OP_W];

    // jirl, b, bl
    assign is_direct = (opcode == bp_pkg::OP_JIRL) ||
                       (opcode == bp_pkg::OP_B)    ||
                       (opcode == bp_pkg::OP_BL);

    // beq .. bgeu
    assign is_cond = (opcode >= bp_pkg::OP_COND_LO) && (opcode <= bp_pkg::OP_COND_HI);

    always_comb begin
        if (is_direct) begin
            class_o = bp_pkg::BR_DIRECT;
        end else if (is_cond) begin
            class_o = bp_pkg::BR_COND;
        end else begin
            class_o = bp_pkg::BR_NONE;
        end
    end

    assign pc_o   = pc_q;
    assign inst_o = inst_q;

endmodule

/* btb.sv */
`timescale 1ns/1ps

module btb (
    input  logic                    clk,
    input  logic                    rstn,
    bp_update_if.sink               upd,
    input  logic [bp_pkg::PC_W-1:0] pc_i,
    output logic                    hit_o,
    output logic [bp_pkg::PC_W-1:0] target_o
);

    logic [bp_pkg::BTB_NUM-1:0]   ent_valid;
    logic [bp_pkg::BTB_TAG_W-1:0] ent_tag    [bp_pkg::BTB_NUM];
    logic [bp_pkg::PC_W-1:0]      ent_target [bp_pkg::BTB_NUM];
    logic [bp_pkg::BTB_PTR_W-1:0] rr_ptr;

    logic [bp_pkg::BTB_NUM-1:0]   rd_hit;
    logic [bp_pkg::BTB_NUM-1:0]   upd_match;
    logic [bp_pkg::BTB_PTR_W-1:0] upd_match_idx;
    logic [bp_pkg::BTB_PTR_W-1:0] wr_idx;
    logic [bp_pkg::BTB_TAG_W-1:0] upd_tag;
    logic                         wr_en;

    assign upd_tag = upd.upd_pc[bp_pkg::BTB_TAG_MSB:bp_pkg::BTB_TAG_LSB];
    assign wr_en   = upd.upd_valid && (upd.upd_class == bp_pkg::BR_DIRECT);

    // lookup for held pc, hit vector is one-hot since tags are unique
    always_comb begin
        target_o = '0;
        for (int i = 0; i < bp_pkg::BTB_NUM; i++) begin
            rd_hit[i] = ent_valid[i] &&
                        (ent_tag[i] == pc_i[bp_pkg::BTB_TAG_MSB:bp_pkg::BTB_TAG_LSB]);
            target_o  = target_o | ({bp_pkg::PC_W{rd_hit[i]}} & ent_target[i]);
        end
    end

    assign hit_o = |rd_hit;

    // existing tag is rewritten in place
    always_comb begin
        upd_match_idx = '0;
        for (int i = 0; i < bp_pkg::BTB_NUM; i++) begin
            upd_match[i] = ent_valid[i] && (ent_tag[i] == upd_tag);
            if (upd_match[i]) begin
                upd_match_idx = bp_pkg::BTB_PTR_W'(i);
            end
        end
    end

    assign wr_idx = (|upd_match) ? upd_match_idx : rr_ptr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ent_valid <= '0;
            rr_ptr    <= '0;
        end else if (wr_en) begin
            ent_valid[wr_idx] <= 1'b1;
            if (!(|upd_match)) begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_tag[wr_idx]    <= upd_tag;
            ent_target[wr_idx] <= upd.upd_target;
        end
    end

endmodule

/* two_level_pred.sv */
`timescale 1ns/1ps

module two_level_pred (
    input  logic                    clk,
    input  logic                    rstn,
    bp_update_if.sink               upd,
    input  logic [bp_pkg::PC_W-1:0] pc_i,
    output logic                    taken_o,
    output logic [bp_pkg::PC_W-1:0] target_o
);

    // per-branch history, indexed by pc hash
    logic [bp_pkg::HIST_W-1:0] bht [bp_pkg::HIST_NUM];
    // 2-bit counters, indexed by history xor low pc bits
    logic [1:0]                pht [bp_pkg::HIST_NUM];
    // taken targets, same index as pht
    logic [bp_pkg::PC_W-1:0]   tc  [bp_pkg::HIST_NUM];

    logic [bp_pkg::HIST_W-1:0] rd_bht_idx;
    logic [bp_pkg::HIST_W-1:0] rd_pht_idx;
    logic [bp_pkg::HIST_W-1:0] wr_bht_idx;
    logic [bp_pkg::HIST_W-1:0] wr_pht_idx;
    logic [bp_pkg::HIST_W-1:0] wr_hist;
    logic                      wr_en;

    // read side, held pc
    assign rd_bht_idx = bp_pkg::pc_hash(pc_i);
    assign rd_pht_idx = bht[rd_bht_idx] ^ pc_i[bp_pkg::HIST_W-1:0];
    assign taken_o    = pht[rd_pht_idx][1];
    assign target_o   = tc[rd_pht_idx];

    // write side, resolve bus
    assign wr_en      = upd.upd_valid && (upd.upd_class == bp_pkg::BR_COND);
    assign wr_bht_idx = bp_pkg::pc_hash(upd.upd_pc);
    assign wr_hist    = bht[wr_bht_idx];
    assign wr_pht_idx = wr_hist ^ upd.upd_pc[bp_pkg::HIST_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::HIST_NUM; i++) begin
                bht[i] <= '0;
            end
        end else if (wr_en) begin
            bht[wr_bht_idx] <= {wr_hist[bp_pkg::HIST_W-2:0], upd.upd_taken};
        end
    end

    // counters start strongly not taken
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::HIST_NUM; i++) begin
                pht[i] <= 2'b00;
            end
        end else if (wr_en) begin
            pht[wr_pht_idx] <= bp_pkg::ctr_next(pht[wr_pht_idx], upd.upd_taken);
        end
    end

    // only taken outcomes carry a useful target
    always_ff @(posedge clk) begin
        if (wr_en && upd.upd_taken) begin
            tc[wr_pht_idx] <= upd.upd_target;
        end
    end

endmodule

/* pre_decode_top.sv */
`timescale 1ns/1ps

module pre_decode_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic [bp_pkg::PC_W-1:0]   in_pc_i,
    input  logic [bp_pkg::INST_W-1:0] in_inst_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [bp_pkg::PC_W-1:0]   out_pc_o,
    output logic [bp_pkg::INST_W-1:0] out_inst_o,
    output bp_pkg::br_class_e         out_class_o,
    output logic                      pred_taken_o,
    output logic [bp_pkg::PC_W-1:0]   pred_target_o,
    output logic                      stall_o,
    input  logic                      flush_i,
    input  logic                      upd_valid_i,
    input  logic [bp_pkg::PC_W-1:0]   upd_pc_i,
    input  bp_pkg::br_class_e         upd_class_i,
    input  logic                      upd_taken_i,
    input  logic [bp_pkg::PC_W-1:0]   upd_target_i
);

    logic                    load;
    logic                    direct_miss;
    logic                    btb_hit;
    logic [bp_pkg::PC_W-1:0] btb_target;
    logic                    tl_taken;
    logic [bp_pkg::PC_W-1:0] tl_target;

    bp_update_if upd_bus ();

    assign upd_bus.upd_valid  = upd_valid_i;
    assign upd_bus.upd_pc     = upd_pc_i;
    assign upd_bus.upd_class  = upd_class_i;
    assign upd_bus.upd_taken  = upd_taken_i;
    assign upd_bus.upd_target = upd_target_i;

    pd_ctrl i_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .in_valid_i    (in_valid_i),
        .out_ready_i   (out_ready_i),
        .flush_i       (flush_i),
        .direct_miss_i (direct_miss),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .load_o        (load),
        .stall_o       (stall_o)
    );

    pd_decode i_decode (
        .clk     (clk),
        .rstn    (rstn),
        .load_i  (load),
        .pc_i    (in_pc_i),
        .inst_i  (in_inst_i),
        .pc_o    (out_pc_o),
        .inst_o  (out_inst_o),
        .class_o (out_class_o)
    );

    btb i_btb (
        .clk      (clk),
        .rstn     (rstn),
        .upd      (upd_bus.sink),
        .pc_i     (out_pc_o),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    two_level_pred i_tlp (
        .clk      (clk),
        .rstn     (rstn),
        .upd      (upd_bus.sink),
        .pc_i     (out_pc_o),
        .taken_o  (tl_taken),
        .target_o (tl_target)
    );

    assign direct_miss = (out_class_o == bp_pkg::BR_DIRECT) && !btb_hit;

    // prediction by class of the held item
    always_comb begin
        case (out_class_o)
            bp_pkg::BR_DIRECT: begin
                pred_taken_o  = btb_hit;
                pred_target_o = btb_target;
            end
            bp_pkg::BR_COND: begin
                pred_taken_o  = tl_taken;
                pred_target_o = tl_taken ? tl_target : '0;
            end
            default: begin
                pred_taken_o  = 1'b0;
                pred_target_o = '0;
            end
        endcase
    end

endmodule

/* tb_bp_model.svh */
`ifndef TB_BP_MODEL_SVH
`define TB_BP_MODEL_SVH

// reference copy of btb, bht, pht and target cache
logic                         m_btb_valid [bp_pkg::BTB_NUM];
logic [bp_pkg::BTB_TAG_W-1:0] m_btb_tag   [bp_pkg::BTB_NUM];
logic [bp_pkg::PC_W-1:0]      m_btb_tgt   [bp_pkg::BTB_NUM];
int unsigned                  m_rr_ptr;
logic [bp_pkg::HIST_W-1:0]    m_bht [bp_pkg::HIST_NUM];
logic [1:0]                   m_pht [bp_pkg::HIST_NUM];
logic [bp_pkg::PC_W-1:0]      m_tc  [bp_pkg::HIST_NUM];

task automatic model_reset();
    for (int i = 0; i < bp_pkg::BTB_NUM; i++) begin
        m_btb_valid[i] = 1'b0;
        m_btb_tag[i]   = '0;
        m_btb_tgt[i]   = '0;
    end
    m_rr_ptr = 0;
    for (int i = 0; i < bp_pkg::HIST_NUM; i++) begin
        m_bht[i] = '0;
        m_pht[i] = 2'b00;
        m_tc[i]  = '0;
    end
endtask

// opcode ranges straight from the instruction set
function automatic bp_pkg::br_class_e class_of(input logic [31:0] inst);
    logic [5:0] op;
    op = inst[31:26];
    if (op == 6'h13 || op == 6'h14 || op == 6'h15) begin
        return bp_pkg::BR_DIRECT;
    end else if (op >= 6'h16 && op <= 6'h1b) begin
        return bp_pkg::BR_COND;
    end
    return bp_pkg::BR_NONE;
endfunction

// entry holding the tag of pc, or -1
function automatic int btb_find(input logic [31:0] pc);
    int idx;
    idx = -1;
    for (int i = 0; i < bp_pkg::BTB_NUM; i++) begin
        if (m_btb_valid[i] && m_btb_tag[i] == pc[13:2]) begin
            idx = i;
        end
    end
    return idx;
endfunction

function automatic logic [4:0] pht_index(input logic [31:0] pc);
    return m_bht[bp_pkg::pc_hash(pc)] ^ pc[4:0];
endfunction

task automatic model_predict(input logic [31:0] pc, input bp_pkg::br_class_e cls,
                             output logic taken, output logic [31:0] target);
    int idx;
    logic [4:0] p;
    taken  = 1'b0;
    target = '0;
    idx    = btb_find(pc);
    p      = pht_index(pc);
    if (cls == bp_pkg::BR_DIRECT && idx >= 0) begin
        taken  = 1'b1;
        target = m_btb_tgt[idx];
    end else if (cls == bp_pkg::BR_COND) begin
        taken  = m_pht[p][1];
        target = taken ? m_tc[p] : '0;
    end
endtask

task automatic model_update(input logic [31:0] pc, input bp_pkg::br_class_e cls,
                            input logic taken, input logic [31:0] target);
    int idx;
    logic [4:0] h;
    logic [4:0] p;
    idx = btb_find(pc);
    h   = bp_pkg::pc_hash(pc);
    p   = pht_index(pc);
    if (cls == bp_pkg::BR_DIRECT) begin
        // new tag takes the round-robin slot
        if (idx < 0) begin
            idx      = int'(m_rr_ptr);
            m_rr_ptr = (m_rr_ptr + 1) % bp_pkg::BTB_NUM;
        end
        m_btb_valid[idx] = 1'b1;
        m_btb_tag[idx]   = pc[13:2];
        m_btb_tgt[idx]   = target;
    end else if (cls == bp_pkg::BR_COND) begin
        m_pht[p] = bp_pkg::ctr_next(m_pht[p], taken);
        m_bht[h] = {m_bht[h][3:0], taken};
        if (taken) begin
            m_tc[p] = target;
        end
    end
endtask

`endif

/* tb_pre_decode.sv */
`timescale 1ns/1ps

module tb_pre_decode;

    localparam int TIMEOUT = 200;
    localparam int N_RAND  = 4000;

    logic                clk;
    logic                rstn;
    logic                in_valid_i;
    logic                in_ready_o;
    logic [31:0]         in_pc_i;
    logic [31:0]         in_inst_i;
    logic                out_valid_o;
    logic                out_ready_i;
    logic [31:0]         out_pc_o;
    logic [31:0]         out_inst_o;
    bp_pkg::br_class_e   out_class_o;
    logic                pred_taken_o;
    logic [31:0]         pred_target_o;
    logic                stall_o;
    logic                flush_i;
    logic                upd_valid_i;
    logic [31:0]         upd_pc_i;
    bp_pkg::br_class_e   upd_class_i;
    logic                upd_taken_i;
    logic [31:0]         upd_target_i;

    logic [31:0]         lcg_state;
    logic [31:0]         sb_pc   [$];
    logic [31:0]         sb_inst [$];
    int unsigned         n_out;

    `include "tb_bp_model.svh"

    pre_decode_top i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_class(input string name, input bp_pkg::br_class_e exp,
                               input bp_pkg::br_class_e act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    function automatic logic [15:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return 32'(lcg()) % n;
    endfunction

    // small pool, distinct btb tags, hashes collide
    function automatic logic [31:0] pool_pc(input int unsigned k);
        return 32'h0010_0000 ^ (k * 32'h0001_0404);
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [5:0] op;
        case (pick(3))
            0: op = (pick(2) == 0) ? 6'(pick(19)) : 6'(28 + pick(36));
            1: op = 6'h13 + 6'(pick(3));
            default: op = 6'h16 + 6'(pick(6));
        endcase
        return {op, 10'(lcg()), lcg()};
    endfunction

    // all inputs are stable between the falling and the rising edge
    task automatic observe();
        bp_pkg::br_class_e cls;
        logic        held_miss;
        logic        leave;
        logic        exp_taken;
        logic [31:0] exp_target;
        cls       = bp_pkg::BR_NONE;
        held_miss = 1'b0;
        if (!rstn) begin
            model_reset();
            sb_pc.delete();
            sb_inst.delete();
            return;
        end
        if (sb_pc.size() != 0) begin
            cls       = class_of(sb_inst[0]);
            held_miss = (cls == bp_pkg::BR_DIRECT) && (btb_find(sb_pc[0]) < 0);
        end
        check_bit("out_valid", sb_pc.size() != 0 && !held_miss, out_valid_o);
        check_bit("stall", held_miss, stall_o);
        leave = out_valid_o && out_ready_i;
        check_bit("in_ready", !flush_i && (sb_pc.size() == 0 || leave), in_ready_o);
        if (leave) begin
            model_predict(sb_pc[0], cls, exp_taken, exp_target);
            check_word("pc", sb_pc.pop_front(), out_pc_o);
            check_word("inst", sb_inst.pop_front(), out_inst_o);
            check_class("class", cls, out_class_o);
            check_bit("taken", exp_taken, pred_taken_o);
            check_word("target", exp_target, pred_target_o);
            n_out++;
        end
        if (flush_i) begin
            sb_pc.delete();
            sb_inst.delete();
        end
        if (in_valid_i && in_ready_o) begin
            sb_pc.push_back(in_pc_i);
            sb_inst.push_back(in_inst_i);
        end
        if (upd_valid_i) begin
            model_update(upd_pc_i, upd_class_i, upd_taken_i, upd_target_i);
        end
    endtask

    task automatic tick();
        #1;
        observe();
        @(negedge clk);
    endtask

    task automatic drive_random();
        in_valid_i  = pick(4) != 0;
        in_pc_i     = pool_pc(pick(12));
        in_inst_i   = rand_inst();
        out_ready_i = pick(4) != 0;
        flush_i     = pick(100) == 0;
        upd_valid_i = pick(2) != 0;
        // steer half the resolves at a stalled jump
        upd_pc_i     = (stall_o && pick(2) == 0) ? out_pc_o : pool_pc(pick(12));
        upd_class_i  = bp_pkg::br_class_e'(pick(3));
        upd_taken_i  = pick(2) != 0;
        upd_target_i = {lcg(), lcg()};
    endtask

    // resolves any stalled jump until the stage is empty
    task automatic drain();
        int unsigned n;
        in_valid_i  = 1'b0;
        flush_i     = 1'b0;
        out_ready_i = 1'b1;
        upd_class_i = bp_pkg::BR_DIRECT;
        n = 0;
        while (sb_pc.size() != 0 && n < TIMEOUT) begin
            upd_valid_i  = stall_o;
            upd_pc_i     = out_pc_o;
            upd_target_i = {lcg(), lcg()};
            tick();
            n++;
        end
        upd_valid_i = 1'b0;
        if (sb_pc.size() != 0) begin
            fail_stop("stage did not drain within the timeout");
        end
    endtask

    task automatic hold_missing_jump(input logic [31:0] pc);
        int unsigned n;
        in_valid_i  = 1'b1;
        in_pc_i     = pc;
        in_inst_i   = {6'h15, 26'h0};
        out_ready_i = 1'b1;
        tick();
        in_valid_i = 1'b0;
        n = 0;
        while (!stall_o && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!stall_o) begin
            fail_stop("direct jump without btb entry did not stall");
        end
        repeat (4) tick();
    endtask

    initial begin
        int unsigned n;
        lcg_state    = 32'h21e8;
        n_out        = 0;
        rstn         = 1'b0;
        in_valid_i   = 1'b0;
        in_pc_i      = '0;
        in_inst_i    = '0;
        out_ready_i  = 1'b0;
        flush_i      = 1'b0;
        upd_valid_i  = 1'b0;
        upd_pc_i     = '0;
        upd_class_i  = bp_pkg::BR_NONE;
        upd_taken_i  = 1'b0;
        upd_target_i = '0;
        model_reset();
        repeat (4) tick();
        rstn = 1'b1;
        #1;
        check_bit("reset out_valid", 1'b0, out_valid_o);
        check_bit("reset stall", 1'b0, stall_o);
        check_bit("reset in_ready", 1'b1, in_ready_o);
        tick();

        repeat (N_RAND) begin
            drive_random();
            tick();
        end
        drain();

        // back-to-back non-branch items
        in_valid_i  = 1'b1;
        out_ready_i = 1'b1;
        repeat (16) begin
            in_pc_i   = pool_pc(pick(12));
            in_inst_i = {6'h01, 10'(lcg()), lcg()};
            #1;
            check_bit("back-to-back in_ready", 1'b1, in_ready_o);
            tick();
        end
        drain();

        // stalled jump released by a resolve
        hold_missing_jump(32'h0000_2af0);
        upd_valid_i  = 1'b1;
        upd_pc_i     = 32'h0000_2af0;
        upd_class_i  = bp_pkg::BR_DIRECT;
        upd_target_i = 32'h1234_5678;
        tick();
        upd_valid_i = 1'b0;
        n = 0;
        while (!out_valid_o && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!out_valid_o) begin
            fail_stop("stalled jump not released after its resolve");
        end
        drain();

        // stalled jump removed by a flush
        hold_missing_jump(32'h0000_2af4);
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        check_bit("flush stall", 1'b0, stall_o);
        check_bit("flush out_valid", 1'b0, out_valid_o);
        tick();

        if (n_out < 500) begin
            fail_stop("too few output transfers");
        end else begin
            $display("%0d output transfers checked", n_out);
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+.
bp_pkg.sv
bp_update_if.sv
pd_ctrl.sv
pd_decode.sv
btb.sv
two_level_pred.sv
pre_decode_top.sv
tb_pre_decode.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pre_decode -f sim.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
